/* design/softmax_pkg.sv */
`default_nettype none

package softmax_pkg;

  // elements per memory word and their width
  localparam int NUM_LANES = 4;
  localparam int ELEM_W = 16;

  // external memory address width
  localparam int ADDR_W = 8;

  // weights are unsigned Q1.15
  localparam int WEIGHT_W = 16;

  // a difference at or above this shifts the weight down to zero
  localparam int SHIFT_LIMIT = 16;

  // 256 words x 4 lanes x 1.0 fits without overflow
  localparam int SUM_W = 26;

  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WEIGHT_W-1:0] weight_t;
  typedef logic [SUM_W-1:0] sum_t;

  // 1.0 in Q1.15, the weight of the maximum element
  localparam weight_t WEIGHT_ONE = weight_t'(32768);

  // one memory word, lane 0 in the low bits
  typedef struct packed {
    elem_t [NUM_LANES-1:0] lane;
  } elem_vec_t;

  // the weights of one vector, same lane order as the word
  typedef struct packed {
    weight_t [NUM_LANES-1:0] lane;
  } weight_vec_t;

endpackage

`default_nettype wire

/* design/pass_sequencer.sv */
`default_nettype none

module pass_sequencer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  softmax_pkg::addr_t     start_addr,
  input  softmax_pkg::addr_t     end_addr,
  input  softmax_pkg::elem_vec_t rd_data,
  output softmax_pkg::addr_t     rd_addr,
  output softmax_pkg::elem_vec_t word,
  output logic                   max_clear,
  output logic                   max_valid,
  output logic                   lane_valid,
  output logic                   last,
  output logic                   busy
);
  import softmax_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_PASS1, S_GAP, S_PASS2, S_DRAIN} state_t;

  state_t state;
  addr_t start_lat;
  addr_t end_lat;
  addr_t last_addr;
  logic rd_live;
  logic at_last;
  logic [1:0] wait_count;

  // end address is exclusive
  assign last_addr = end_lat - addr_t'(1);
  assign at_last = rd_live && (rd_addr == last_addr);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      rd_addr <= '0;
      rd_live <= 1'b0;
      wait_count <= '0;
      busy <= 1'b0;
      max_clear <= 1'b0;
      max_valid <= 1'b0;
      lane_valid <= 1'b0;
      last <= 1'b0;
    end else begin
      max_clear <= 1'b0;
      // strobes follow the word register, one cycle behind rd_addr
      max_valid <= rd_live && (state == S_PASS1);
      lane_valid <= rd_live && (state == S_PASS2);
      last <= at_last && (state == S_PASS2);
      case (state)
        S_IDLE: begin
          if (start) begin
            busy <= 1'b1;
            max_clear <= 1'b1;
            state <= S_PASS1;
          end
        end
        S_PASS1: begin
          if (!rd_live) begin
            rd_addr <= start_lat;
            rd_live <= 1'b1;
          end else if (at_last) begin
            rd_live <= 1'b0;
            wait_count <= '0;
            state <= S_GAP;
          end else begin
            rd_addr <= rd_addr + addr_t'(1);
          end
        end
        // two idle cycles while the last pass-1 word settles the maximum
        S_GAP: begin
          if (wait_count == 2'd1) begin
            rd_addr <= start_lat;
            rd_live <= 1'b1;
            state <= S_PASS2;
          end else begin
            wait_count <= wait_count + 2'd1;
          end
        end
        S_PASS2: begin
          if (at_last) begin
            rd_live <= 1'b0;
            wait_count <= '0;
            state <= S_DRAIN;
          end else begin
            rd_addr <= rd_addr + addr_t'(1);
          end
        end
        // lane, pair, accumulate and done stages still in flight
        S_DRAIN: begin
          if (wait_count == 2'd3) begin
            busy <= 1'b0;
            state <= S_IDLE;
          end else begin
            wait_count <= wait_count + 2'd1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == S_IDLE) && start) begin
      start_lat <= start_addr;
      end_lat <= end_addr;
    end
    if (rd_live) begin
      word <= rd_data;
    end
  end

  a_start_idle: assert property (@(posedge clk) disable iff (reset) busy |-> !start);
  a_range: assert property (@(posedge clk) disable iff (reset)
    (start && !busy) |-> (end_addr > start_addr));

endmodule

`default_nettype wire

/* design/max_tree.sv */
`default_nettype none

module max_tree (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   max_clear,
  input  logic                   max_valid,
  input  softmax_pkg::elem_vec_t word,
  output softmax_pkg::elem_t     max_value
);
  import softmax_pkg::*;

  elem_t win_lo;
  elem_t win_hi;
  elem_t win_word;
  elem_t win_all;

  // first level, lanes 0/1 and 2/3
  assign win_lo = ($signed(word.lane[0]) > $signed(word.lane[1])) ?
                  word.lane[0] : word.lane[1];
  assign win_hi = ($signed(word.lane[2]) > $signed(word.lane[3])) ?
                  word.lane[2] : word.lane[3];

  // second level picks the word maximum
  assign win_word = ($signed(win_lo) > $signed(win_hi)) ? win_lo : win_hi;

  // against the maximum seen so far in pass 1
  assign win_all = ($signed(win_word) > $signed(max_value)) ? win_word : max_value;

  always_ff @(posedge clk) begin
    if (reset) begin
      max_value <= {1'b1, {(ELEM_W - 1){1'b0}}};
    end else if (max_clear) begin
      // most negative value so any element wins
      max_value <= {1'b1, {(ELEM_W - 1){1'b0}}};
    end else if (max_valid) begin
      max_value <= win_all;
    end
  end

  // the running maximum never drops and covers every lane just folded in
  a_max_monotonic: assert property (@(posedge clk) disable iff (reset)
    (max_valid && !max_clear) |=>
      ($signed(max_value) >= $signed($past(max_value))) &&
      ($signed(max_value) >= $signed($past(word.lane[0]))) &&
      ($signed(max_value) >= $signed($past(word.lane[1]))) &&
      ($signed(max_value) >= $signed($past(word.lane[2]))) &&
      ($signed(max_value) >= $signed($past(word.lane[3]))));

endmodule

`default_nettype wire

/* design/exp_lane.sv */
`default_nettype none

module exp_lane (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 lane_valid,
  input  softmax_pkg::elem_t   elem,
  input  softmax_pkg::elem_t   max_value,
  output softmax_pkg::weight_t weight,
  output logic                 weight_valid
);
  import softmax_pkg::*;

  // max minus element, one extra bit so the full signed spread fits
  logic [ELEM_W:0] diff;

  assign diff = {max_value[ELEM_W-1], max_value} - {elem[ELEM_W-1], elem};

  always_ff @(posedge clk) begin
    if (reset) begin
      weight_valid <= 1'b0;
    end else begin
      weight_valid <= lane_valid;
    end
  end

  // 2^-diff in Q1.15, underflows to zero past the last fraction bit
  always_ff @(posedge clk) begin
    if (lane_valid) begin
      if (diff >= (ELEM_W + 1)'(SHIFT_LIMIT)) begin
        weight <= '0;
      end else begin
        weight <= WEIGHT_ONE >> diff[$clog2(SHIFT_LIMIT)-1:0];
      end
    end
  end

  // pass 2 elements never exceed the maximum found in pass 1
  a_weight_range: assert property (@(posedge clk) disable iff (reset)
    lane_valid |-> ($signed(elem) <= $signed(max_value)));

endmodule

`default_nettype wire

/* design/sum_tree.sv */
`default_nettype none

module sum_tree (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_valid,
  input  logic                     last,
  input  softmax_pkg::weight_vec_t weights,
  output softmax_pkg::sum_t        sum_out,
  output logic                     done
);
  import softmax_pkg::*;

  logic [WEIGHT_W:0] pair_lo;
  logic [WEIGHT_W:0] pair_hi;
  logic pair_valid;
  logic pair_last;
  logic last_d;
  logic acc_last;
  logic fresh;
  sum_t vec_sum;

  assign vec_sum = sum_t'(pair_lo) + sum_t'(pair_hi);

  // pair stage
  always_ff @(posedge clk) begin
    if (in_valid) begin
      pair_lo <= {1'b0, weights.lane[0]} + {1'b0, weights.lane[1]};
      pair_hi <= {1'b0, weights.lane[2]} + {1'b0, weights.lane[3]};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      last_d <= 1'b0;
      pair_valid <= 1'b0;
      pair_last <= 1'b0;
      acc_last <= 1'b0;
      done <= 1'b0;
      fresh <= 1'b1;
      sum_out <= '0;
    end else begin
      // last comes with the word, one cycle ahead of the lane weights
      last_d <= last;
      pair_valid <= in_valid;
      pair_last <= in_valid && last_d;
      acc_last <= pair_valid && pair_last;
      done <= acc_last;
      if (pair_valid) begin
        sum_out <= (fresh ? '0 : sum_out) + vec_sum;
        fresh <= 1'b0;
      end
      // total holds after done until the next run's first vector
      if (done) begin
        fresh <= 1'b1;
      end
    end
  end

  a_no_wrap: assert property (@(posedge clk) disable iff (reset)
    (pair_valid && !fresh) |=> (sum_out >= $past(sum_out)));

endmodule

`default_nettype wire

/* design/softmax_exp2.sv */
`default_nettype none

module softmax_exp2 (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  softmax_pkg::addr_t       start_addr,
  input  softmax_pkg::addr_t       end_addr,
  input  softmax_pkg::elem_vec_t   rd_data,
  output softmax_pkg::addr_t       rd_addr,
  output wire softmax_pkg::weight_vec_t weight_out,
  output logic                     weight_valid,
  output softmax_pkg::sum_t        sum_out,
  output logic                     done,
  output logic                     busy
);
  import softmax_pkg::*;

  elem_vec_t word;
  elem_t max_value;
  logic max_clear;
  logic max_valid;
  logic lane_valid;
  logic last;
  wire [NUM_LANES-1:0] lane_valid_q;

  pass_sequencer u_seq (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .start_addr (start_addr),
    .end_addr   (end_addr),
    .rd_data    (rd_data),
    .rd_addr    (rd_addr),
    .word       (word),
    .max_clear  (max_clear),
    .max_valid  (max_valid),
    .lane_valid (lane_valid),
    .last       (last),
    .busy       (busy)
  );

  max_tree u_max (
    .clk       (clk),
    .reset     (reset),
    .max_clear (max_clear),
    .max_valid (max_valid),
    .word      (word),
    .max_value (max_value)
  );

  // one lane per element, all share the maximum
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    exp_lane u_lane (
      .clk          (clk),
      .reset        (reset),
      .lane_valid   (lane_valid),
      .elem         (word.lane[i]),
      .max_value    (max_value),
      .weight       (weight_out.lane[i]),
      .weight_valid (lane_valid_q[i])
    );
  end

  assign weight_valid = lane_valid_q[0];

  // the sum takes a vector once every lane has its weight
  sum_tree u_sum (
    .clk      (clk),
    .reset    (reset),
    .in_valid (&lane_valid_q),
    .last     (last),
    .weights  (weight_out),
    .sum_out  (sum_out),
    .done     (done)
  );

endmodule

`default_nettype wire

/* tb/clock_gen.sv */
`default_nettype none

module clock_gen (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // reset held over the first 3 rising edges
  initial begin
    reset = 1'b1;
    repeat (3) begin
      @(posedge clk);
    end
    #1 reset = 1'b0;
  end

endmodule

`default_nettype wire

/* tb/tb_softmax_exp2.sv */
`default_nettype none

module tb_softmax_exp2;
  timeunit 1ns;
  timeprecision 100ps;
  import softmax_pkg::*;

  typedef enum int {FILL_WIDE, FILL_NEG, FILL_NARROW, FILL_EQUAL} fill_t;

  logic clk;
  logic reset;
  logic start;
  addr_t start_addr;
  addr_t end_addr;
  elem_vec_t rd_data;
  addr_t rd_addr;
  weight_vec_t weight_out;
  logic weight_valid;
  sum_t sum_out;
  logic done;
  logic busy;

  elem_vec_t mem [0:255];

  // expected values of the current run
  addr_t run_start;
  int run_n;
  elem_t run_max;
  sum_t exp_sum;
  logic started_any;
  int error_count;

  // run progress seen at the outputs
  int wv_count;
  int done_count;
  logic saw_one;
  logic run_active;
  logic held_valid;
  sum_t held_sum;
  addr_t exp_addr;
  weight_vec_t exp_vec;
  logic full_lane;
  addr_t rd_addr_d1;
  addr_t rd_addr_d2;

  clock_gen u_clk (
    .clk   (clk),
    .reset (reset)
  );

  softmax_exp2 uut (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .start_addr   (start_addr),
    .end_addr     (end_addr),
    .rd_data      (rd_data),
    .rd_addr      (rd_addr),
    .weight_out   (weight_out),
    .weight_valid (weight_valid),
    .sum_out      (sum_out),
    .done         (done),
    .busy         (busy)
  );

  // memory answers in the same cycle
  assign rd_data = mem[rd_addr];

  task automatic stop_with_error(input string what);
    error_count++;
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopped at the first error");
  endtask

  // 2^-(max - elem) in Q1.15, zero once the shift passes the fraction bits
  function automatic weight_t ref_weight(elem_t mx, elem_t el);
    int diff;
    diff = int'(mx) - int'(el);
    if (diff >= SHIFT_LIMIT) begin
      return '0;
    end
    return WEIGHT_ONE >> diff;
  endfunction

  function automatic weight_vec_t ref_vector(elem_vec_t w, elem_t mx);
    weight_vec_t v;
    for (int i = 0; i < NUM_LANES; i++) begin
      v.lane[i] = ref_weight(mx, w.lane[i]);
    end
    return v;
  endfunction

  function automatic elem_t range_max(addr_t first, int n);
    elem_t best;
    best = elem_t'(16'h8000);
    for (int a = int'(first); a < int'(first) + n; a++) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (mem[a].lane[i] > best) begin
          best = mem[a].lane[i];
        end
      end
    end
    return best;
  endfunction

  function automatic sum_t range_sum(addr_t first, int n, elem_t mx);
    sum_t total;
    total = '0;
    for (int a = int'(first); a < int'(first) + n; a++) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        total = total + sum_t'(ref_weight(mx, mem[a].lane[i]));
      end
    end
    return total;
  endfunction

  // words outside the range stay fully random
  task automatic fill_memory(input fill_t mode, input addr_t first, input addr_t stop);
    int base;
    elem_t same;
    base = int'($urandom_range(40000)) - 20000;
    same = elem_t'($urandom);
    for (int a = 0; a < 256; a++) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (a < int'(first) || a >= int'(stop) || mode == FILL_WIDE) begin
          mem[a].lane[i] = elem_t'($urandom);
        end else if (mode == FILL_NEG) begin
          mem[a].lane[i] = elem_t'($urandom | 32'h0000_8000);
        end else if (mode == FILL_NARROW) begin
          mem[a].lane[i] = elem_t'(base + int'($urandom_range(12)));
        end else begin
          mem[a].lane[i] = same;
        end
      end
    end
  endtask

  task automatic run_range(input fill_t mode, input addr_t first, input addr_t stop);
    int cycles;
    fill_memory(mode, first, stop);
    run_start = first;
    run_n = int'(stop) - int'(first);
    run_max = range_max(first, run_n);
    exp_sum = range_sum(first, run_n, run_max);
    start_addr = first;
    end_addr = stop;
    start = 1'b1;
    started_any = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    cycles = 0;
    while (!done && cycles < 2 * run_n + 40) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!done) begin
      stop_with_error($sformatf("done never came within %0d cycles of start", cycles));
    end
    repeat (3) begin
      @(posedge clk);
    end
    #1;
  endtask

  assign exp_addr = run_start + addr_t'(wv_count);
  assign exp_vec = ref_vector(mem[exp_addr], run_max);
  assign full_lane = (weight_out.lane[0] == WEIGHT_ONE) || (weight_out.lane[1] == WEIGHT_ONE) ||
                     (weight_out.lane[2] == WEIGHT_ONE) || (weight_out.lane[3] == WEIGHT_ONE);

  // read address of the word behind each weight, two cycles earlier
  always_ff @(posedge clk) begin
    rd_addr_d1 <= rd_addr;
    rd_addr_d2 <= rd_addr_d1;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wv_count <= 0;
      done_count <= 0;
      saw_one <= 1'b0;
      run_active <= 1'b0;
      held_valid <= 1'b0;
      held_sum <= '0;
    end else if (start && !busy) begin
      wv_count <= 0;
      done_count <= 0;
      saw_one <= 1'b0;
      run_active <= 1'b1;
      held_valid <= 1'b0;
    end else begin
      if (weight_valid) begin
        wv_count <= wv_count + 1;
        if (full_lane) begin
          saw_one <= 1'b1;
        end
      end
      if (done) begin
        done_count <= done_count + 1;
        run_active <= 1'b0;
        held_valid <= 1'b1;
        held_sum <= exp_sum;
      end
    end
  end

  a_reset_state: assert property (@(posedge clk) disable iff (reset)
    !started_any |-> (!busy && !done && !weight_valid && sum_out == '0))
    else stop_with_error($sformatf("FAILED reset state busy=%h done=%h weight_valid=%h sum_out=%h",
      $sampled(busy), $sampled(done), $sampled(weight_valid), $sampled(sum_out)));

  a_weight: assert property (@(posedge clk) disable iff (reset)
    weight_valid |-> (weight_out == exp_vec))
    else stop_with_error($sformatf("FAILED weight_out at addr %h got %h expected %h",
      $sampled(exp_addr), $sampled(weight_out), $sampled(exp_vec)));

  a_read_addr: assert property (@(posedge clk) disable iff (reset)
    weight_valid |-> (rd_addr_d2 == exp_addr))
    else stop_with_error($sformatf("FAILED rd_addr got %h expected %h",
      $sampled(rd_addr_d2), $sampled(exp_addr)));

  a_weight_count: assert property (@(posedge clk) disable iff (reset)
    weight_valid |-> (run_active && wv_count < run_n))
    else stop_with_error("weight_valid pulsed beyond the vectors of the run");

  a_done_once: assert property (@(posedge clk) disable iff (reset)
    done |-> (run_active && done_count == 0))
    else stop_with_error("done pulsed twice or outside a run");

  a_done_last: assert property (@(posedge clk) disable iff (reset)
    done |-> (wv_count == run_n))
    else stop_with_error($sformatf("FAILED weight_valid count at done got %h expected %h",
      $sampled(wv_count), $sampled(run_n)));

  a_max_seen: assert property (@(posedge clk) disable iff (reset)
    done |-> saw_one)
    else stop_with_error("no lane carried the full weight of the range maximum");

  a_sum: assert property (@(posedge clk) disable iff (reset)
    done |-> (sum_out == exp_sum))
    else stop_with_error($sformatf("FAILED sum_out got %h expected %h",
      $sampled(sum_out), $sampled(exp_sum)));

  a_sum_held: assert property (@(posedge clk) disable iff (reset)
    held_valid |-> (sum_out == held_sum))
    else stop_with_error($sformatf("FAILED sum_out after done got %h expected %h",
      $sampled(sum_out), $sampled(held_sum)));

  a_busy_high: assert property (@(posedge clk) disable iff (reset)
    (run_active && !done) |-> busy)
    else stop_with_error($sformatf("FAILED busy got %h expected 1", $sampled(busy)));

  a_busy_low: assert property (@(posedge clk) disable iff (reset)
    (!run_active || done) |-> !busy)
    else stop_with_error($sformatf("FAILED busy got %h expected 0", $sampled(busy)));

  initial begin
    int unsigned seed_dummy;
    int cycles;
    int s;
    int n;
    start = 1'b0;
    start_addr = '0;
    end_addr = '0;
    started_any = 1'b0;
    error_count = 0;
    run_start = '0;
    run_n = 0;
    run_max = '0;
    exp_sum = '0;
    seed_dummy = $urandom(32'h4b01_f2c0);
    fill_memory(FILL_WIDE, '0, '0);

    cycles = 0;
    while (reset !== 1'b0 && cycles < 20) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (reset !== 1'b0) begin
      stop_with_error("reset was never released");
    end
    // idle cycles so the reset state is observed
    repeat (4) begin
      @(posedge clk);
    end
    #1;

    run_range(FILL_WIDE, 8'd10, 8'd42);
    run_range(FILL_NARROW, 8'd0, 8'd16);
    run_range(FILL_WIDE, 8'd100, 8'd101);
    run_range(FILL_NEG, 8'd200, 8'd255);
    run_range(FILL_EQUAL, 8'd50, 8'd70);
    run_range(FILL_NARROW, 8'd3, 8'd4);
    for (int k = 0; k < 6; k++) begin
      s = int'($urandom_range(250));
      n = int'($urandom_range(255 - s, 1));
      run_range(fill_t'(k % 4), addr_t'(s), addr_t'(s + n));
    end

    if (error_count == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      stop_with_error("errors were counted during the run");
    end
  end

endmodule

`default_nettype wire

/* softmax_exp2.f */
design/softmax_pkg.sv
design/pass_sequencer.sv
design/max_tree.sv
design/exp_lane.sv
design/sum_tree.sv
design/softmax_exp2.sv
tb/clock_gen.sv
tb/tb_softmax_exp2.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

top=tb_softmax_exp2
build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module "$top" -f softmax_exp2.f -Mdir "$build_dir" -o "$top"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/$top" > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "Regression failed" "$log"; then
  echo "simulation reported a failure, see $log"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
if ! grep -q "Regression passed" "$log"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
